//--- common/rv_id_pkg.sv
package rv_id_pkg;

	localparam int XLEN     = 32;
	localparam int REG_AW   = 5;
	localparam int ALUOP_W  = 8;
	localparam int ALUSEL_W = 3;

	// Major opcodes
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_OPI    = 7'b0010011;
	localparam logic [6:0] OP_OP     = 7'b0110011;

	localparam logic [2:0] F3_JALR    = 3'b000;
	localparam logic [2:0] F3_BEQ     = 3'b000;
	localparam logic [2:0] F3_BNE     = 3'b001;
	localparam logic [2:0] F3_BLT     = 3'b100;
	localparam logic [2:0] F3_BGE     = 3'b101;
	localparam logic [2:0] F3_BLTU    = 3'b110;
	localparam logic [2:0] F3_BGEU    = 3'b111;
	localparam logic [2:0] F3_LB      = 3'b000;
	localparam logic [2:0] F3_LH      = 3'b001;
	localparam logic [2:0] F3_LW      = 3'b010;
	localparam logic [2:0] F3_LBU     = 3'b100;
	localparam logic [2:0] F3_LHU     = 3'b101;
	localparam logic [2:0] F3_SB      = 3'b000;
	localparam logic [2:0] F3_SH      = 3'b001;
	localparam logic [2:0] F3_SW      = 3'b010;
	localparam logic [2:0] F3_ADD_SUB = 3'b000; // Also ADDI
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	localparam logic [6:0] F7_ALT = 7'b0100000; // Instruction bit 30

	localparam logic [ALUOP_W-1:0] ALU_NOP   = 8'h00;
	localparam logic [ALUOP_W-1:0] ALU_ADD   = 8'h01;
	localparam logic [ALUOP_W-1:0] ALU_SUB   = 8'h02;
	localparam logic [ALUOP_W-1:0] ALU_SLT   = 8'h03;
	localparam logic [ALUOP_W-1:0] ALU_SLTU  = 8'h04;
	localparam logic [ALUOP_W-1:0] ALU_AND   = 8'h05;
	localparam logic [ALUOP_W-1:0] ALU_OR    = 8'h06;
	localparam logic [ALUOP_W-1:0] ALU_XOR   = 8'h07;
	localparam logic [ALUOP_W-1:0] ALU_SLL   = 8'h08;
	localparam logic [ALUOP_W-1:0] ALU_SRL   = 8'h09;
	localparam logic [ALUOP_W-1:0] ALU_SRA   = 8'h0a;
	localparam logic [ALUOP_W-1:0] ALU_AUIPC = 8'h0b;
	localparam logic [ALUOP_W-1:0] ALU_JAL   = 8'h10;
	localparam logic [ALUOP_W-1:0] ALU_JALR  = 8'h11;
	localparam logic [ALUOP_W-1:0] ALU_BEQ   = 8'h12;
	localparam logic [ALUOP_W-1:0] ALU_BNE   = 8'h13;
	localparam logic [ALUOP_W-1:0] ALU_BLT   = 8'h14;
	localparam logic [ALUOP_W-1:0] ALU_BGE   = 8'h15;
	localparam logic [ALUOP_W-1:0] ALU_BLTU  = 8'h16;
	localparam logic [ALUOP_W-1:0] ALU_BGEU  = 8'h17;
	localparam logic [ALUOP_W-1:0] ALU_LB    = 8'h20;
	localparam logic [ALUOP_W-1:0] ALU_LH    = 8'h21;
	localparam logic [ALUOP_W-1:0] ALU_LW    = 8'h22;
	localparam logic [ALUOP_W-1:0] ALU_LBU   = 8'h23;
	localparam logic [ALUOP_W-1:0] ALU_LHU   = 8'h24;
	localparam logic [ALUOP_W-1:0] ALU_SB    = 8'h28;
	localparam logic [ALUOP_W-1:0] ALU_SH    = 8'h29;
	localparam logic [ALUOP_W-1:0] ALU_SW    = 8'h2a;

	localparam logic [ALUSEL_W-1:0] SEL_NOP   = 3'd0;
	localparam logic [ALUSEL_W-1:0] SEL_LOGIC = 3'd1;
	localparam logic [ALUSEL_W-1:0] SEL_ARITH = 3'd2;
	localparam logic [ALUSEL_W-1:0] SEL_SHIFT = 3'd3;
	localparam logic [ALUSEL_W-1:0] SEL_JB    = 3'd4;
	localparam logic [ALUSEL_W-1:0] SEL_LDST  = 3'd5;

	typedef struct packed {
		logic [6:0]        funct7;
		logic [REG_AW-1:0] rs2;
		logic [REG_AW-1:0] rs1;
		logic [2:0]        funct3;
		logic [REG_AW-1:0] rd;
		logic [6:0]        opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0]       imm;
		logic [REG_AW-1:0] rs1;
		logic [2:0]        funct3;
		logic [REG_AW-1:0] rd;
		logic [6:0]        opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0]        imm_hi;
		logic [REG_AW-1:0] rs2;
		logic [REG_AW-1:0] rs1;
		logic [2:0]        funct3;
		logic [4:0]        imm_lo;
		logic [6:0]        opcode;
	} s_fmt_t;

	typedef struct packed {
		logic              imm12;
		logic [5:0]        imm10_5;
		logic [REG_AW-1:0] rs2;
		logic [REG_AW-1:0] rs1;
		logic [2:0]        funct3;
		logic [3:0]        imm4_1;
		logic              imm11;
		logic [6:0]        opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0]       imm;
		logic [REG_AW-1:0] rd;
		logic [6:0]        opcode;
	} u_fmt_t;

	typedef struct packed {
		logic              imm20;
		logic [9:0]        imm10_1;
		logic              imm11;
		logic [7:0]        imm19_12;
		logic [REG_AW-1:0] rd;
		logic [6:0]        opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} inst_u;

	typedef struct packed {
		logic [XLEN-1:0]     pc;
		logic [ALUOP_W-1:0]  aluop;
		logic [ALUSEL_W-1:0] alusel;
		logic                rd_en;
		logic [REG_AW-1:0]   rd_addr;
		logic                rs1_en;
		logic [REG_AW-1:0]   rs1_addr;
		logic                rs2_en;
		logic [REG_AW-1:0]   rs2_addr;
		logic [XLEN-1:0]     imm;
		logic                is_load;
	} dec_t;

	typedef struct packed {
		logic              is_load; // Only meaningful on the EX port
		logic              w_en;
		logic [REG_AW-1:0] w_addr;
		logic [XLEN-1:0]   w_data;
	} fwd_t;

	typedef struct packed {
		logic [XLEN-1:0]     pc;
		logic [ALUOP_W-1:0]  aluop;
		logic [ALUSEL_W-1:0] alusel;
		logic [XLEN-1:0]     op1;
		logic [XLEN-1:0]     op2;
		logic                w_en;
		logic [REG_AW-1:0]   w_addr;
		logic [XLEN-1:0]     offset;
	} id_ex_t;

	typedef struct packed {
		logic            taken;
		logic [XLEN-1:0] target;
	} branch_t;

endpackage

//--- design/id_decode.sv
`timescale 1ns/1ps

module id_decode
	import rv_id_pkg::*;
(
	input  logic            clk,
	input  logic            rst,
	input  logic            inst_valid_i,
	input  inst_u           inst_i,
	input  logic [XLEN-1:0] pc_i,
	input  logic            hold_i,
	output dec_t            dec_o,
	output logic            dec_valid_o
);

	logic [6:0]          opcode;
	logic [2:0]          funct3;
	logic                alt;
	logic [XLEN-1:0]     imm_i;
	logic [XLEN-1:0]     imm_iz;
	logic [XLEN-1:0]     imm_sh;
	logic [XLEN-1:0]     imm_s;
	logic [XLEN-1:0]     imm_b;
	logic [XLEN-1:0]     imm_u;
	logic [XLEN-1:0]     imm_j;
	logic [ALUOP_W-1:0]  aluop;
	logic [ALUSEL_W-1:0] alusel;
	logic                rd_en;
	logic                rs1_en;
	logic                rs2_en;
	logic [XLEN-1:0]     imm;
	logic                is_load;
	dec_t                dec_d;
	dec_t                dec_q;
	logic                valid_q;

	assign opcode = inst_i.r_fmt.opcode;
	assign funct3 = inst_i.r_fmt.funct3;
	assign alt    = |(inst_i.r_fmt.funct7 & F7_ALT);

	assign imm_i  = {{20{inst_i.i_fmt.imm[11]}}, inst_i.i_fmt.imm};
	assign imm_iz = {20'h0, inst_i.i_fmt.imm}; // Logic immediates
	assign imm_sh = {27'h0, inst_i.r_fmt.rs2}; // shamt
	assign imm_s  = {{20{inst_i.s_fmt.imm_hi[6]}}, inst_i.s_fmt.imm_hi, inst_i.s_fmt.imm_lo};
	assign imm_b  = {{19{inst_i.b_fmt.imm12}}, inst_i.b_fmt.imm12, inst_i.b_fmt.imm11,
		inst_i.b_fmt.imm10_5, inst_i.b_fmt.imm4_1, 1'b0};
	assign imm_u  = {inst_i.u_fmt.imm, 12'h0};
	assign imm_j  = {{11{inst_i.j_fmt.imm20}}, inst_i.j_fmt.imm20, inst_i.j_fmt.imm19_12,
		inst_i.j_fmt.imm11, inst_i.j_fmt.imm10_1, 1'b0};

	// Anything left at ALU_NOP keeps every enable low
	always_comb
	begin
		aluop   = ALU_NOP;
		alusel  = SEL_NOP;
		rd_en   = 1'b0;
		rs1_en  = 1'b0;
		rs2_en  = 1'b0;
		imm     = '0;
		is_load = 1'b0;
		case (opcode)
			OP_LUI:
			begin
				aluop  = ALU_OR;
				alusel = SEL_LOGIC;
				rd_en  = 1'b1;
				imm    = imm_u;
			end
			OP_AUIPC:
			begin
				aluop  = ALU_AUIPC;
				alusel = SEL_ARITH;
				rd_en  = 1'b1;
				imm    = imm_u;
			end
			OP_JAL:
			begin
				aluop  = ALU_JAL;
				alusel = SEL_JB;
				rd_en  = 1'b1;
				imm    = imm_j;
			end
			OP_JALR:
			begin
				if (funct3 == F3_JALR)
				begin
					aluop  = ALU_JALR;
					alusel = SEL_JB;
					rd_en  = 1'b1;
					rs1_en = 1'b1;
					imm    = imm_i;
				end
			end
			OP_BRANCH:
			begin
				case (funct3)
					F3_BEQ:  aluop = ALU_BEQ;
					F3_BNE:  aluop = ALU_BNE;
					F3_BLT:  aluop = ALU_BLT;
					F3_BGE:  aluop = ALU_BGE;
					F3_BLTU: aluop = ALU_BLTU;
					F3_BGEU: aluop = ALU_BGEU;
					default: aluop = ALU_NOP;
				endcase
				if (aluop != ALU_NOP)
				begin
					rs1_en = 1'b1;
					rs2_en = 1'b1;
					imm    = imm_b;
				end
			end
			OP_LOAD:
			begin
				case (funct3)
					F3_LB:   aluop = ALU_LB;
					F3_LH:   aluop = ALU_LH;
					F3_LW:   aluop = ALU_LW;
					F3_LBU:  aluop = ALU_LBU;
					F3_LHU:  aluop = ALU_LHU;
					default: aluop = ALU_NOP;
				endcase
				if (aluop != ALU_NOP)
				begin
					alusel  = SEL_LDST;
					rd_en   = 1'b1;
					rs1_en  = 1'b1;
					imm     = imm_i;
					is_load = 1'b1;
				end
			end
			OP_STORE:
			begin
				case (funct3)
					F3_SB:   aluop = ALU_SB;
					F3_SH:   aluop = ALU_SH;
					F3_SW:   aluop = ALU_SW;
					default: aluop = ALU_NOP;
				endcase
				if (aluop != ALU_NOP)
				begin
					alusel = SEL_LDST;
					rs1_en = 1'b1;
					rs2_en = 1'b1;
					imm    = imm_s;
				end
			end
			OP_OPI:
			begin
				rd_en  = 1'b1;
				rs1_en = 1'b1;
				case (funct3)
					F3_ADD_SUB:
					begin
						aluop  = ALU_ADD;
						alusel = SEL_ARITH;
						imm    = imm_i;
					end
					F3_SLT:
					begin
						aluop  = ALU_SLT;
						alusel = SEL_ARITH;
						imm    = imm_i;
					end
					F3_SLTU:
					begin
						aluop  = ALU_SLTU;
						alusel = SEL_ARITH;
						imm    = imm_i;
					end
					F3_SLL:
					begin
						aluop  = ALU_SLL;
						alusel = SEL_SHIFT;
						imm    = imm_sh;
					end
					F3_SRL_SRA:
					begin
						aluop  = alt ? ALU_SRA : ALU_SRL;
						alusel = SEL_SHIFT;
						imm    = imm_sh;
					end
					default:
					begin
						alusel = SEL_LOGIC;
						imm    = imm_iz;
						if (funct3 == F3_XOR)
							aluop = ALU_XOR;
						else if (funct3 == F3_OR)
							aluop = ALU_OR;
						else
							aluop = ALU_AND;
					end
				endcase
			end
			OP_OP:
			begin
				rd_en  = 1'b1;
				rs1_en = 1'b1;
				rs2_en = 1'b1;
				case (funct3)
					F3_ADD_SUB: aluop = alt ? ALU_SUB : ALU_ADD;
					F3_SLT:     aluop = ALU_SLT;
					F3_SLTU:    aluop = ALU_SLTU;
					F3_SLL:     aluop = ALU_SLL;
					F3_SRL_SRA: aluop = alt ? ALU_SRA : ALU_SRL;
					F3_XOR:     aluop = ALU_XOR;
					F3_OR:      aluop = ALU_OR;
					default:    aluop = ALU_AND;
				endcase
				if (funct3 == F3_SLL || funct3 == F3_SRL_SRA)
					alusel = SEL_SHIFT;
				else if (funct3 == F3_ADD_SUB || funct3 == F3_SLT || funct3 == F3_SLTU)
					alusel = SEL_ARITH;
				else
					alusel = SEL_LOGIC;
			end
			default:
			begin
			end
		endcase
	end

	// Register addresses read as zero when unused
	always_comb
	begin
		dec_d.pc       = pc_i;
		dec_d.aluop    = aluop;
		dec_d.alusel   = alusel;
		dec_d.rd_en    = rd_en;
		dec_d.rd_addr  = rd_en ? inst_i.r_fmt.rd : '0;
		dec_d.rs1_en   = rs1_en;
		dec_d.rs1_addr = rs1_en ? inst_i.r_fmt.rs1 : '0;
		dec_d.rs2_en   = rs2_en;
		dec_d.rs2_addr = rs2_en ? inst_i.r_fmt.rs2 : '0;
		dec_d.imm      = imm;
		dec_d.is_load  = is_load;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			valid_q <= 1'b0;
		else if (!hold_i)
			valid_q <= inst_valid_i;
	end

	always_ff @(posedge clk)
	begin
		if (inst_valid_i && !hold_i)
			dec_q <= dec_d;
	end

	assign dec_o       = dec_q;
	assign dec_valid_o = valid_q;

endmodule

//--- design/id_branch_resolve.sv
`timescale 1ns/1ps

module id_branch_resolve
	import rv_id_pkg::*;
(
	input  logic [ALUOP_W-1:0] aluop_i,
	input  logic [XLEN-1:0]    pc_i,
	input  logic [XLEN-1:0]    op1_i,
	input  logic [XLEN-1:0]    op2_i,
	input  logic [XLEN-1:0]    imm_i,
	output branch_t            branch_o
);

	logic            eq;
	logic            lt_s;
	logic            lt_u;
	logic [XLEN-1:0] pc_rel;
	logic [XLEN-1:0] reg_rel;

	assign eq      = (op1_i == op2_i);
	assign lt_s    = $signed(op1_i) < $signed(op2_i);
	assign lt_u    = op1_i < op2_i;
	assign pc_rel  = pc_i + imm_i;
	assign reg_rel = op1_i + imm_i; // JALR keeps bit 0

	always_comb
	begin
		branch_o.taken  = 1'b0;
		branch_o.target = pc_rel;
		case (aluop_i)
			ALU_JAL:  branch_o.taken = 1'b1;
			ALU_JALR:
			begin
				branch_o.taken  = 1'b1;
				branch_o.target = reg_rel;
			end
			ALU_BEQ:  branch_o.taken = eq;
			ALU_BNE:  branch_o.taken = !eq;
			ALU_BLT:  branch_o.taken = lt_s;
			ALU_BGE:  branch_o.taken = !lt_s;
			ALU_BLTU: branch_o.taken = lt_u;
			ALU_BGEU: branch_o.taken = !lt_u;
			default:
			begin
				branch_o.taken  = 1'b0;
				branch_o.target = '0;
			end
		endcase
	end

endmodule

//--- design/id_operand_stage.sv
`timescale 1ns/1ps

module id_operand_stage
	import rv_id_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  dec_t              dec_i,
	input  logic              dec_valid_i,
	input  fwd_t              ex_fwd_i,
	input  fwd_t              mem_fwd_i,
	input  logic [XLEN-1:0]   rf_r1_data_i,
	input  logic [XLEN-1:0]   rf_r2_data_i,
	output logic              rf_r1_en_o,
	output logic [REG_AW-1:0] rf_r1_addr_o,
	output logic              rf_r2_en_o,
	output logic [REG_AW-1:0] rf_r2_addr_o,
	output logic              stall_o,
	output id_ex_t            id_ex_o,
	output branch_t           branch_o,
	output logic              out_valid_o
);

	// Returns {stall, operand}
	function automatic logic [XLEN:0] resolve_op(
		input logic              en,
		input logic [REG_AW-1:0] addr,
		input logic [XLEN-1:0]   rf_data,
		input logic [XLEN-1:0]   imm,
		input fwd_t              ex,
		input fwd_t              mem
	);
		logic live;
		logic ex_hit;
		logic mem_hit;
		live    = en && (addr != '0);
		ex_hit  = live && (ex.w_addr == addr);
		mem_hit = live && mem.w_en && (mem.w_addr == addr);
		if (!en)
			return {1'b0, imm};
		else if (ex_hit && ex.is_load)
			return {1'b1, rf_data}; // Load-use, data not ready yet
		else if (ex_hit && ex.w_en)
			return {1'b0, ex.w_data};
		else if (mem_hit)
			return {1'b0, mem.w_data};
		else
			return {1'b0, rf_data};
	endfunction

	logic [XLEN:0] res1;
	logic [XLEN:0] res2;
	logic          advance;
	branch_t       br;
	id_ex_t        id_ex_q;
	logic          valid_q;
	logic          taken_q;
	logic [XLEN-1:0] target_q;

	assign rf_r1_en_o   = dec_valid_i && dec_i.rs1_en;
	assign rf_r2_en_o   = dec_valid_i && dec_i.rs2_en;
	assign rf_r1_addr_o = rf_r1_en_o ? dec_i.rs1_addr : '0;
	assign rf_r2_addr_o = rf_r2_en_o ? dec_i.rs2_addr : '0;

	assign res1 = resolve_op(dec_i.rs1_en, dec_i.rs1_addr, rf_r1_data_i, dec_i.imm,
		ex_fwd_i, mem_fwd_i);
	assign res2 = resolve_op(dec_i.rs2_en, dec_i.rs2_addr, rf_r2_data_i, dec_i.imm,
		ex_fwd_i, mem_fwd_i);

	assign stall_o = dec_valid_i && (res1[XLEN] || res2[XLEN]);
	assign advance = dec_valid_i && !stall_o;

	id_branch_resolve i_id_branch_resolve (
		.aluop_i  (dec_i.aluop),
		.pc_i     (dec_i.pc),
		.op1_i    (res1[XLEN-1:0]),
		.op2_i    (res2[XLEN-1:0]),
		.imm_i    (dec_i.imm),
		.branch_o (br)
	);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_q <= 1'b0;
			taken_q <= 1'b0;
		end
		else
		begin
			valid_q <= advance;
			taken_q <= advance && br.taken; // Redirect lasts one cycle
		end
	end

	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			id_ex_q.pc     <= dec_i.pc;
			id_ex_q.aluop  <= dec_i.aluop;
			id_ex_q.alusel <= dec_i.alusel;
			id_ex_q.op1    <= res1[XLEN-1:0];
			id_ex_q.op2    <= res2[XLEN-1:0];
			id_ex_q.w_en   <= dec_i.rd_en;
			id_ex_q.w_addr <= dec_i.rd_addr;
			id_ex_q.offset <= dec_i.imm;
			target_q       <= br.target;
		end
	end

	assign id_ex_o         = id_ex_q;
	assign out_valid_o     = valid_q;
	assign branch_o.taken  = taken_q;
	assign branch_o.target = target_q;

endmodule

//--- design/rv_id_top.sv
`timescale 1ns/1ps

module rv_id_top
	import rv_id_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              inst_valid_i,
	input  inst_u             inst_i,
	input  logic [XLEN-1:0]   pc_i,
	output logic              rf_r1_en_o,
	output logic [REG_AW-1:0] rf_r1_addr_o,
	output logic              rf_r2_en_o,
	output logic [REG_AW-1:0] rf_r2_addr_o,
	input  logic [XLEN-1:0]   rf_r1_data_i,
	input  logic [XLEN-1:0]   rf_r2_data_i,
	input  fwd_t              ex_fwd_i,
	input  fwd_t              mem_fwd_i,
	output logic              stall_o,
	output id_ex_t            id_ex_o,
	output branch_t           branch_o,
	output logic              out_valid_o
);

	dec_t dec;
	logic dec_valid;
	logic stall;
	fwd_t mem_fwd;

	// MEM results are never pending loads
	assign mem_fwd = '{is_load: 1'b0, w_en: mem_fwd_i.w_en, w_addr: mem_fwd_i.w_addr,
		w_data: mem_fwd_i.w_data};

	id_decode i_id_decode (
		.clk          (clk),
		.rst          (rst),
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.pc_i         (pc_i),
		.hold_i       (stall),
		.dec_o        (dec),
		.dec_valid_o  (dec_valid)
	);

	id_operand_stage i_id_operand_stage (
		.clk          (clk),
		.rst          (rst),
		.dec_i        (dec),
		.dec_valid_i  (dec_valid),
		.ex_fwd_i     (ex_fwd_i),
		.mem_fwd_i    (mem_fwd),
		.rf_r1_data_i (rf_r1_data_i),
		.rf_r2_data_i (rf_r2_data_i),
		.rf_r1_en_o   (rf_r1_en_o),
		.rf_r1_addr_o (rf_r1_addr_o),
		.rf_r2_en_o   (rf_r2_en_o),
		.rf_r2_addr_o (rf_r2_addr_o),
		.stall_o      (stall),
		.id_ex_o      (id_ex_o),
		.branch_o     (branch_o),
		.out_valid_o  (out_valid_o)
	);

	assign stall_o = stall;

endmodule

//--- bench/rv_id_assert.sv
`timescale 1ns/1ps

module rv_id_assert
	import rv_id_pkg::*;
(
	input logic    clk,
	input logic    rst,
	input logic    inst_valid_i,
	input logic    stall_o,
	input logic    out_valid_o,
	input branch_t branch_o
);

	int n_viol = 0;

	// Upstream must hold off during a stall
	a_no_strobe_in_stall: assert property (@(posedge clk) disable iff (rst)
		stall_o |-> !inst_valid_i)
		else
		begin
			$error("strobe while stall_o is high");
			n_viol++;
		end

	a_no_out_in_stall: assert property (@(posedge clk) disable iff (rst)
		!(out_valid_o && stall_o))
		else
		begin
			$error("out_valid_o high during a stall");
			n_viol++;
		end

	a_reset_state: assert property (@(posedge clk)
		rst |=> (!out_valid_o && !stall_o && !branch_o.taken))
		else
		begin
			$error("outputs not idle after reset");
			n_viol++;
		end

endmodule

bind rv_id_top rv_id_assert i_rv_id_assert (.*);

//--- bench/rv_id_checker.sv
`timescale 1ns/1ps

module rv_id_checker
	import rv_id_pkg::*;
(
	input logic              clk,
	input logic              rst,
	input logic              inst_valid_i,
	input logic              stall_i,
	input logic              out_valid_i,
	input id_ex_t            id_ex_i,
	input branch_t           branch_i,
	input logic              rf_r1_en_i,
	input logic [REG_AW-1:0] rf_r1_addr_i,
	input logic              rf_r2_en_i,
	input logic [REG_AW-1:0] rf_r2_addr_i
);

	id_ex_t      exp_q[$];
	branch_t     br_q[$];
	int          stall_q[$];
	logic [11:0] rf_q[$];
	int          strobe_q[$];
	logic [11:0] rf_last = '0; // Read request of the cycle before each output
	int          cycle = 0;
	int          stall_acc = 0;
	int          n_done = 0;
	int          n_fail = 0;
	int          n_errors = 0;

	task automatic push_expected(input id_ex_t e, input branch_t b, input int stalls,
		input logic [11:0] reads);
		exp_q.push_back(e);
		br_q.push_back(b);
		stall_q.push_back(stalls);
		rf_q.push_back(reads);
	endtask

	task automatic check_val(input string name, input logic [31:0] e, input logic [31:0] a,
		inout int bad);
		if (e !== a)
		begin
			$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, e, a);
			bad++;
		end
	endtask

	task automatic compare_head();
		id_ex_t      e;
		branch_t     b;
		logic [11:0] r;
		int          st;
		int          lat;
		int          bad;
		e   = exp_q.pop_front();
		b   = br_q.pop_front();
		r   = rf_q.pop_front();
		st  = stall_q.pop_front();
		lat = cycle - strobe_q.pop_front();
		bad = 0;
		check_val("id_ex_o.pc", e.pc, id_ex_i.pc, bad);
		check_val("id_ex_o.aluop", e.aluop, id_ex_i.aluop, bad);
		check_val("id_ex_o.alusel", e.alusel, id_ex_i.alusel, bad);
		check_val("id_ex_o.op1", e.op1, id_ex_i.op1, bad);
		check_val("id_ex_o.op2", e.op2, id_ex_i.op2, bad);
		check_val("id_ex_o.w_en", e.w_en, id_ex_i.w_en, bad);
		check_val("id_ex_o.w_addr", e.w_addr, id_ex_i.w_addr, bad);
		check_val("id_ex_o.offset", e.offset, id_ex_i.offset, bad);
		check_val("branch_o.taken", b.taken, branch_i.taken, bad);
		check_val("branch_o.target", b.target, branch_i.target, bad);
		check_val("rf_r1_en_o", r[11], rf_last[11], bad);
		check_val("rf_r1_addr_o", r[10:6], rf_last[10:6], bad);
		check_val("rf_r2_en_o", r[5], rf_last[5], bad);
		check_val("rf_r2_addr_o", r[4:0], rf_last[4:0], bad);
		check_val("stall cycles", st, stall_acc, bad);
		check_val("latency", 2 + st, lat, bad);
		$display("test %0d: %s", n_done, (bad == 0) ? "ok" : "mismatch");
		if (bad != 0)
			n_fail++;
		n_done++;
		stall_acc = 0;
	endtask

	always @(posedge clk)
	begin
		if (!rst)
		begin
			cycle++;
			if (inst_valid_i)
				strobe_q.push_back(cycle);
			if (out_valid_i && stall_i)
			begin
				$display("Output strobe seen while the stall was high at %0t", $time);
				n_errors++;
			end
			if (out_valid_i && (exp_q.size() == 0 || strobe_q.size() == 0))
			begin
				$display("Unexpected output with no pending test at %0t", $time);
				n_errors++;
			end
			else if (out_valid_i)
				compare_head();
			if (stall_i)
				stall_acc++;
			rf_last = {rf_r1_en_i, rf_r1_addr_i, rf_r2_en_i, rf_r2_addr_i};
		end
	end

	task automatic print_summary();
		$display("%0d tests run, %0d passed, %0d failed, %0d other errors",
			n_done, n_done - n_fail, n_fail, n_errors);
	endtask

endmodule

//--- bench/tb_rv_id.sv
`timescale 1ns/1ps

module tb_rv_id
	import rv_id_pkg::*;
();

	localparam int K_NONE = 0;
	localparam int K_I    = 1;
	localparam int K_IZ   = 2;
	localparam int K_SH   = 3;
	localparam int K_S    = 4;
	localparam int K_B    = 5;
	localparam int K_U    = 6;
	localparam int K_J    = 7;

	typedef struct packed {
		logic [31:0] inst;
		logic [31:0] pc;
		fwd_t        ex;
		fwd_t        mem;
		id_ex_t      exp;
		branch_t     br;
		logic [11:0] rf_rd;
		logic [7:0]  stalls;
	} test_t;

	logic              clk;
	logic              rst;
	logic              inst_valid;
	logic [31:0]       inst;
	logic [XLEN-1:0]   pc;
	fwd_t              ex_fwd;
	fwd_t              mem_fwd;
	logic              rf_r1_en;
	logic [REG_AW-1:0] rf_r1_addr;
	logic              rf_r2_en;
	logic [REG_AW-1:0] rf_r2_addr;
	logic [XLEN-1:0]   rf_r1_data;
	logic [XLEN-1:0]   rf_r2_data;
	logic              stall;
	id_ex_t            id_ex;
	branch_t           branch;
	logic              out_valid;
	test_t             tests[$];
	logic [31:0]       seed;
	logic              timeout_hit;

	always #5 clk = ~clk;

	// Register file model
	assign rf_r1_data = rf_r1_addr * 32'h01010101;
	assign rf_r2_data = rf_r2_addr * 32'h01010101;

	rv_id_top i_rv_id_top (
		.clk          (clk),
		.rst          (rst),
		.inst_valid_i (inst_valid),
		.inst_i       (inst),
		.pc_i         (pc),
		.rf_r1_en_o   (rf_r1_en),
		.rf_r1_addr_o (rf_r1_addr),
		.rf_r2_en_o   (rf_r2_en),
		.rf_r2_addr_o (rf_r2_addr),
		.rf_r1_data_i (rf_r1_data),
		.rf_r2_data_i (rf_r2_data),
		.ex_fwd_i     (ex_fwd),
		.mem_fwd_i    (mem_fwd),
		.stall_o      (stall),
		.id_ex_o      (id_ex),
		.branch_o     (branch),
		.out_valid_o  (out_valid)
	);

	rv_id_checker i_checker (
		.clk          (clk),
		.rst          (rst),
		.inst_valid_i (inst_valid),
		.stall_i      (stall),
		.out_valid_i  (out_valid),
		.id_ex_i      (id_ex),
		.branch_i     (branch),
		.rf_r1_en_i   (rf_r1_en),
		.rf_r1_addr_i (rf_r1_addr),
		.rf_r2_en_i   (rf_r2_en),
		.rf_r2_addr_i (rf_r2_addr)
	);

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	function automatic fwd_t mk_fwd(input logic ld, input logic en, input logic [4:0] a,
		input logic [31:0] d);
		fwd_t f;
		f.is_load = ld;
		f.w_en    = en;
		f.w_addr  = a;
		f.w_data  = d;
		return f;
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OP_OP};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] im, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {im, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] im, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {im[11:5], rs2, rs1, f3, im[4:0], OP_STORE};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] im, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {im[12], im[10:5], rs2, rs1, f3, im[4:1], im[11], OP_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] im, input logic [4:0] rd);
		return {im[20], im[10:1], im[11], im[19:12], rd, OP_JAL};
	endfunction

	function automatic logic [31:0] imm_of(input logic [31:0] w, input int kind);
		case (kind)
			K_I:     return {{20{w[31]}}, w[31:20]};
			K_IZ:    return {20'h0, w[31:20]};
			K_SH:    return {27'h0, w[24:20]};
			K_S:     return {{20{w[31]}}, w[31:25], w[11:7]};
			K_B:     return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			K_U:     return {w[31:12], 12'h0};
			K_J:     return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			default: return 32'h0;
		endcase
	endfunction

	// EX beats MEM beats the register file, x0 never forwards
	function automatic logic [31:0] operand(input logic en, input logic [4:0] a,
		input logic [31:0] imm, input fwd_t ex, input fwd_t mem);
		if (!en)
			return imm;
		if (a != 0 && ex.w_en && ex.w_addr == a)
			return ex.w_data;
		if (a != 0 && mem.w_en && mem.w_addr == a)
			return mem.w_data;
		return a * 32'h01010101;
	endfunction

	function automatic branch_t branch_expect(input logic [7:0] op, input logic [31:0] p,
		input logic [31:0] a, input logic [31:0] b, input logic [31:0] imm);
		branch_t r;
		r.taken  = 1'b0;
		r.target = p + imm;
		case (op)
			ALU_JAL:  r.taken = 1'b1;
			ALU_JALR:
			begin
				r.taken  = 1'b1;
				r.target = a + imm;
			end
			ALU_BEQ:  r.taken = (a == b);
			ALU_BNE:  r.taken = (a != b);
			ALU_BLT:  r.taken = ($signed(a) < $signed(b));
			ALU_BGE:  r.taken = !($signed(a) < $signed(b));
			ALU_BLTU: r.taken = (a < b);
			ALU_BGEU: r.taken = !(a < b);
			default:  r.target = 32'h0;
		endcase
		return r;
	endfunction

	task automatic add_test(input logic [31:0] w, input logic [31:0] p, input fwd_t ex,
		input fwd_t mem, input logic [7:0] op, input logic [2:0] sel, input logic rd_en,
		input logic r1_en, input logic r2_en, input int kind, input int stalls);
		test_t t;
		fwd_t  ex_late;
		logic [31:0] imm;
		imm             = imm_of(w, kind);
		ex_late         = ex;
		ex_late.is_load = 1'b0; // Cleared by the drive loop before the output
		t.inst          = w;
		t.pc            = p;
		t.ex            = ex;
		t.mem           = mem;
		t.exp.pc        = p;
		t.exp.aluop     = op;
		t.exp.alusel    = sel;
		t.exp.op1       = operand(r1_en, w[19:15], imm, ex_late, mem);
		t.exp.op2       = operand(r2_en, w[24:20], imm, ex_late, mem);
		t.exp.w_en      = rd_en;
		t.exp.w_addr    = rd_en ? w[11:7] : 5'd0;
		t.exp.offset    = imm;
		t.br            = branch_expect(op, p, t.exp.op1, t.exp.op2, imm);
		t.rf_rd         = {r1_en, r1_en ? w[19:15] : 5'd0, r2_en, r2_en ? w[24:20] : 5'd0};
		t.stalls        = stalls[7:0];
		tests.push_back(t);
	endtask

	task automatic build_table(output int n_seq);
		fwd_t z;
		fwd_t ld;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [4:0] rc;
		z = '0;
		add_test(enc_r(7'h00, 2, 1, F3_ADD_SUB, 3), 32'h100, z, z, ALU_ADD, SEL_ARITH,
			1, 1, 1, K_NONE, 0);
		add_test(enc_r(F7_ALT, 6, 5, F3_ADD_SUB, 4), 32'h104, z, z, ALU_SUB, SEL_ARITH,
			1, 1, 1, K_NONE, 0);
		add_test(enc_r(F7_ALT, 9, 8, F3_SRL_SRA, 7), 32'h108, z, z, ALU_SRA, SEL_SHIFT,
			1, 1, 1, K_NONE, 0);
		add_test(enc_i({F7_ALT, 5'd5}, 11, F3_SRL_SRA, 10, OP_OPI), 32'h10c, z, z, ALU_SRA,
			SEL_SHIFT, 1, 1, 0, K_SH, 0);
		add_test(enc_i(12'hf0f, 13, F3_AND, 12, OP_OPI), 32'h110, z, z, ALU_AND, SEL_LOGIC,
			1, 1, 0, K_IZ, 0);
		add_test(enc_i(12'hffd, 15, F3_SLT, 14, OP_OPI), 32'h114, z, z, ALU_SLT, SEL_ARITH,
			1, 1, 0, K_I, 0);
		add_test({20'h80001, 5'd16, OP_LUI}, 32'h118, z, z, ALU_OR, SEL_LOGIC,
			1, 0, 0, K_U, 0);
		add_test({20'h00abc, 5'd17, OP_AUIPC}, 32'h11c, z, z, ALU_AUIPC, SEL_ARITH,
			1, 0, 0, K_U, 0);
		add_test(enc_i(12'hff8, 19, F3_LW, 18, OP_LOAD), 32'h120, z, z, ALU_LW, SEL_LDST,
			1, 1, 0, K_I, 0);
		add_test(enc_i(12'h7ff, 20, F3_LBU, 21, OP_LOAD), 32'h124, z, z, ALU_LBU, SEL_LDST,
			1, 1, 0, K_I, 0);
		add_test(enc_s(12'h010, 20, 21, F3_SW), 32'h128, z, z, ALU_SW, SEL_LDST,
			0, 1, 1, K_S, 0);
		add_test(enc_s(12'h801, 22, 23, F3_SH), 32'h12c, z, z, ALU_SH, SEL_LDST,
			0, 1, 1, K_S, 0);
		// Forwarding priority
		add_test(enc_r(7'h00, 7, 6, F3_ADD_SUB, 5), 32'h200, mk_fwd(0, 1, 6, 32'haaaa0001),
			mk_fwd(0, 1, 6, 32'hbbbb0001), ALU_ADD, SEL_ARITH, 1, 1, 1, K_NONE, 0);
		add_test(enc_r(7'h00, 7, 6, F3_ADD_SUB, 5), 32'h204, mk_fwd(0, 1, 9, 32'haaaa0002),
			mk_fwd(0, 1, 7, 32'hbbbb0002), ALU_ADD, SEL_ARITH, 1, 1, 1, K_NONE, 0);
		add_test(enc_r(7'h00, 2, 0, F3_ADD_SUB, 1), 32'h208, mk_fwd(0, 1, 0, 32'haaaa0003),
			mk_fwd(0, 1, 0, 32'hbbbb0003), ALU_ADD, SEL_ARITH, 1, 1, 1, K_NONE, 0);
		add_test(enc_r(7'h00, 7, 6, F3_OR, 5), 32'h20c, mk_fwd(0, 0, 6, 32'haaaa0004),
			mk_fwd(0, 1, 6, 32'hbbbb0004), ALU_OR, SEL_LOGIC, 1, 1, 1, K_NONE, 0);
		// Load-use on rs1, then rs2
		add_test(enc_r(7'h00, 5, 4, F3_ADD_SUB, 3), 32'h300, mk_fwd(1, 1, 4, 32'h12345678),
			z, ALU_ADD, SEL_ARITH, 1, 1, 1, K_NONE, 2);
		add_test(enc_r(7'h00, 5, 4, F3_XOR, 3), 32'h304, mk_fwd(1, 1, 5, 32'h9abcdef0),
			z, ALU_XOR, SEL_LOGIC, 1, 1, 1, K_NONE, 1);
		add_test(enc_j(21'h1ff800, 1), 32'h1000, z, z, ALU_JAL, SEL_JB, 1, 0, 0, K_J, 0);
		add_test(enc_i(12'h00d, 5, F3_JALR, 1, OP_JALR), 32'h1004, z, z, ALU_JALR, SEL_JB,
			1, 1, 0, K_I, 0);
		add_test(enc_b(13'h0010, 1, 1, F3_BEQ), 32'h1008, z, z, ALU_BEQ, SEL_NOP,
			0, 1, 1, K_B, 0);
		add_test(enc_b(13'h1ff0, 1, 1, F3_BNE), 32'h100c, z, z, ALU_BNE, SEL_NOP,
			0, 1, 1, K_B, 0);
		// Signed and unsigned edges on x2 and x3
		ld = mk_fwd(0, 1, 2, 32'h80000000);
		z.w_en   = 1'b1;
		z.w_addr = 5'd3;
		z.w_data = 32'h7fffffff;
		add_test(enc_b(13'h0020, 3, 2, F3_BLT), 32'h1010, ld, z, ALU_BLT, SEL_NOP,
			0, 1, 1, K_B, 0);
		add_test(enc_b(13'h1fe0, 3, 2, F3_BGE), 32'h1014, ld, z, ALU_BGE, SEL_NOP,
			0, 1, 1, K_B, 0);
		add_test(enc_b(13'h0040, 3, 2, F3_BLTU), 32'h1018, ld, z, ALU_BLTU, SEL_NOP,
			0, 1, 1, K_B, 0);
		add_test(enc_b(13'h1fc0, 3, 2, F3_BGEU), 32'h101c, ld, z, ALU_BGEU, SEL_NOP,
			0, 1, 1, K_B, 0);
		z = '0;
		add_test(32'hffff_ffff, 32'h2000, z, z, ALU_NOP, SEL_NOP, 0, 0, 0, K_NONE, 0);
		add_test(enc_i(12'h004, 3, 3'b011, 4, OP_LOAD), 32'h2004, z, z, ALU_NOP, SEL_NOP,
			0, 0, 0, K_NONE, 0);
		n_seq = tests.size();
		// Random rows, strobed back to back
		for (int i = 0; i < 8; i++)
		begin
			ra = lcg_next() >> 11;
			rb = lcg_next() >> 11;
			rc = lcg_next() >> 11;
			if (i % 2 == 0)
				add_test(enc_i(lcg_next() >> 7, rb, F3_ADD_SUB, ra, OP_OPI), 32'h3000 + 4 * i,
					z, z, ALU_ADD, SEL_ARITH, 1, 1, 0, K_I, 0);
			else
				add_test(enc_b(lcg_next() >> 9, rc, rb, F3_BLTU), 32'h3000 + 4 * i,
					z, z, ALU_BLTU, SEL_NOP, 0, 1, 1, K_B, 0);
		end
	endtask

	task automatic strobe(input test_t t);
		inst       = t.inst;
		pc         = t.pc;
		ex_fwd     = t.ex;
		mem_fwd    = t.mem;
		inst_valid = 1'b1;
	endtask

	initial
	begin
		int n_seq;
		int seen;
		int cnt;
		clk         = 1'b0;
		rst         = 1'b1;
		inst_valid  = 1'b0;
		inst        = '0;
		pc          = '0;
		ex_fwd      = '0;
		mem_fwd     = '0;
		timeout_hit = 1'b0;
		seed        = 32'd88422;
		build_table(n_seq);
		repeat (3) @(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < n_seq && !timeout_hit; i++)
		begin
			i_checker.push_expected(tests[i].exp, tests[i].br, tests[i].stalls,
				tests[i].rf_rd);
			@(negedge clk);
			strobe(tests[i]);
			@(negedge clk);
			inst_valid = 1'b0;
			seen       = 0;
			cnt        = 0;
			while (i_checker.n_done < i + 1 && cnt < 20)
			begin
				if (stall)
					seen++;
				if (seen > tests[i].stalls)
					ex_fwd.is_load = 1'b0; // Load data now on the EX port
				@(negedge clk);
				cnt++;
			end
			if (i_checker.n_done < i + 1)
			begin
				$display("Timeout: no output for test %0d within 20 cycles", i);
				timeout_hit = 1'b1;
			end
		end
		for (int i = n_seq; i < tests.size() && !timeout_hit; i++)
		begin
			i_checker.push_expected(tests[i].exp, tests[i].br, tests[i].stalls,
				tests[i].rf_rd);
			strobe(tests[i]);
			@(negedge clk);
		end
		inst_valid = 1'b0;
		cnt        = 0;
		while (!timeout_hit && i_checker.n_done < tests.size() && cnt < 20)
		begin
			@(negedge clk);
			cnt++;
		end
		if (!timeout_hit && i_checker.n_done < tests.size())
		begin
			$display("Timeout: back-to-back outputs did not all arrive");
			timeout_hit = 1'b1;
		end
		i_checker.print_summary();
		if (!timeout_hit && i_checker.n_fail == 0 && i_checker.n_errors == 0
			&& i_rv_id_top.i_rv_id_assert.n_viol == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

//--- rv_id.f
common/rv_id_pkg.sv
design/id_decode.sv
design/id_branch_resolve.sv
design/id_operand_stage.sv
design/rv_id_top.sv
bench/rv_id_assert.sv
bench/rv_id_checker.sv
bench/tb_rv_id.sv

//--- Bender.yml
package:
  name: rv_id

sources:
  - common/rv_id_pkg.sv
  - design/id_decode.sv
  - design/id_branch_resolve.sv
  - design/id_operand_stage.sv
  - design/rv_id_top.sv
  - target: test
    files:
      - bench/rv_id_assert.sv
      - bench/rv_id_checker.sv
      - bench/tb_rv_id.sv
